// File: sources.f
+incdir+hw
+incdir+verification
hw/exe_isa_pkg.sv
hw/exe_exc_pkg.sv
hw/exe_alu.sv
hw/exe_branch_unit.sv
hw/exe_mem_align.sv
hw/exe_stage.sv
verification/exe_stage_tb.sv

// File: Bender.yml
package:
  name: exe_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/exe_isa_pkg.sv
      - hw/exe_exc_pkg.sv
      - hw/exe_alu.sv
      - hw/exe_branch_unit.sv
      - hw/exe_mem_align.sv
      - hw/exe_stage.sv
  - target: simulation
    include_dirs:
      - hw
      - verification
    files:
      - verification/exe_stage_tb.sv

// File: verification/exe_stage_vectors.svh
`default_nettype none

`ifndef EXE_STAGE_VECTORS_SVH
`define EXE_STAGE_VECTORS_SVH

// one row per test: name, opcode, operands, then expected results
task automatic fill_table();
    vec_t r;
    vecs.push_back(alu_row("add", ALU_ADD, 32'd5, 32'd7, 32'd12, EXC_NONE));
    vecs.push_back(alu_row("add_ov", ALU_ADD, 32'h7fffffff, 32'd1, 32'h80000000, EXC_OV));
    vecs.push_back(alu_row("addu_no_ov", ALU_ADDU, 32'h7fffffff, 32'd1, 32'h80000000, EXC_NONE));
    r = alu_row("sub_stall", ALU_SUB, 32'd10, 32'd3, 32'd7, EXC_NONE);
    r.stall = 4;   // memory stage busy for four cycles
    vecs.push_back(r);
    vecs.push_back(alu_row("sub_ov", ALU_SUB, 32'h80000000, 32'd1, 32'h7fffffff, EXC_OV));
    vecs.push_back(alu_row("subu", ALU_SUBU, 32'd3, 32'd5, 32'hfffffffe, EXC_NONE));
    vecs.push_back(alu_row("and", ALU_AND, 32'hf0f0ff00, 32'h0ff0f0f0, 32'h00f0f000, EXC_NONE));
    vecs.push_back(alu_row("or", ALU_OR, 32'hf0f0ff00, 32'h0ff0f0f0, 32'hfff0fff0, EXC_NONE));
    vecs.push_back(alu_row("xor", ALU_XOR, 32'hf0f0ff00, 32'h0ff0f0f0, 32'hff000ff0, EXC_NONE));
    vecs.push_back(alu_row("nor", ALU_NOR, 32'hf0f0ff00, 32'h0ff0f0f0, 32'h000f000f, EXC_NONE));
    vecs.push_back(alu_row("slt", ALU_SLT, 32'hffffffff, 32'd1, 32'd1, EXC_NONE));
    vecs.push_back(alu_row("sltu", ALU_SLTU, 32'hffffffff, 32'd1, 32'd0, EXC_NONE));
    vecs.push_back(alu_row("sll", ALU_SLL, 32'd4, 32'h00000011, 32'h00000110, EXC_NONE));
    vecs.push_back(alu_row("srl", ALU_SRL, 32'd8, 32'h80000000, 32'h00800000, EXC_NONE));
    vecs.push_back(alu_row("sra", ALU_SRA, 32'd8, 32'h80000000, 32'hff800000, EXC_NONE));
    vecs.push_back(alu_row("lui", ALU_LUI, 32'd0, 32'h00001234, 32'h12340000, EXC_NONE));
    // branches: op, rs, rt, imm_target, prediction, then taken, target, flush
    vecs.push_back(br_row("beq_pred_ok", BR_BEQ, 32'd5, 32'd5, 32'h80001100,
                          1, 1, 32'h80001100, 1, 32'h80001100, 0));
    vecs.push_back(br_row("bne_bad_target", BR_BNE, 32'd5, 32'd6, 32'h80001100,
                          1, 1, 32'h80002000, 1, 32'h80001100, 1));
    vecs.push_back(br_row("bgez_not_taken", BR_BGEZ, 32'hffffffff, 32'd0, 32'h80001100,
                          1, 0, 32'h0, 0, 32'h0, 0));
    vecs.push_back(br_row("bgtz_unpredicted", BR_BGTZ, 32'd1, 32'd0, 32'h80001200,
                          0, 0, 32'h0, 1, 32'h80001200, 1));
    vecs.push_back(br_row("blez_zero", BR_BLEZ, 32'd0, 32'd0, 32'h80001300,
                          1, 1, 32'h80001300, 1, 32'h80001300, 0));
    vecs.push_back(br_row("bltz_mispredicted", BR_BLTZ, 32'd0, 32'd0, 32'h80001300,
                          1, 1, 32'h80001300, 0, 32'h0, 1));
    vecs.push_back(br_row("j", BR_J, 32'd0, 32'd0, 32'h00000040,
                          0, 0, 32'h0, 1, 32'h80000100, 1));
    vecs.push_back(br_row("jal", BR_JAL, 32'd0, 32'd0, 32'h00000100,
                          1, 1, 32'h80000400, 1, 32'h80000400, 0));
    vecs.push_back(br_row("jr", BR_JR, 32'h80003000, 32'd0, 32'h0,
                          1, 1, 32'h0, 1, 32'h80003000, 1));
    // memory: op, base, offset, rt, lanes, write data, exception
    vecs.push_back(mem_row("sb_0", MEM_SB, 32'h1000, 0, 32'h112233aa, 4'b0001, 32'haaaaaaaa, EXC_NONE));
    vecs.push_back(mem_row("sb_1", MEM_SB, 32'h1000, 1, 32'h112233aa, 4'b0010, 32'haaaaaaaa, EXC_NONE));
    vecs.push_back(mem_row("sb_2", MEM_SB, 32'h1000, 2, 32'h112233aa, 4'b0100, 32'haaaaaaaa, EXC_NONE));
    vecs.push_back(mem_row("sb_3", MEM_SB, 32'h1000, 3, 32'h112233aa, 4'b1000, 32'haaaaaaaa, EXC_NONE));
    vecs.push_back(mem_row("sh_0", MEM_SH, 32'h1000, 0, 32'h1122bbcc, 4'b0011, 32'hbbccbbcc, EXC_NONE));
    vecs.push_back(mem_row("sh_2", MEM_SH, 32'h1000, 2, 32'h1122bbcc, 4'b1100, 32'hbbccbbcc, EXC_NONE));
    vecs.push_back(mem_row("sw", MEM_SW, 32'h1000, 0, 32'h12345678, 4'b1111, 32'h12345678, EXC_NONE));
    vecs.push_back(mem_row("lw_ok", MEM_LW, 32'h1000, 4, 32'h5, 4'b0000, 32'h5, EXC_NONE));
    vecs.push_back(mem_row("lw_misaligned", MEM_LW, 32'h1000, 2, 32'h5, 4'b0000, 32'h5, EXC_ADEL));
    vecs.push_back(mem_row("lh_misaligned", MEM_LH, 32'h1000, 1, 32'h5, 4'b0000, 32'h5, EXC_ADEL));
    vecs.push_back(mem_row("sw_misaligned", MEM_SW, 32'h1000, 1, 32'h5, 4'b0000, 32'h5, EXC_ADES));
    // decode exception beats overflow
    r = alu_row("ex_over_ov", ALU_ADD, 32'h7fffffff, 32'd1, 32'h80000000, EXC_SYS);
    r.ex = 1'b1;
    r.code = EXC_SYS;
    vecs.push_back(r);
    // overflow beats a misaligned store address
    r = alu_row("ov_over_ades", ALU_ADD, 32'h7fffffff, 32'd2, 32'h80000001, EXC_OV);
    r.mem_op = MEM_SW;
    r.gr_we = 1'b0;
    vecs.push_back(r);
endtask

`endif

`default_nettype wire

// File: verification/exe_stage_tb.sv
`timescale 1ns/1ps
`include "exe_config.svh"
`default_nettype none

module exe_stage_tb import exe_isa_pkg::*, exe_exc_pkg::*; ();

    localparam logic [`EXE_XLEN-1:0] BASE_PC = 32'h80001000;
    localparam int WAIT_LIMIT = 50;

    typedef struct {
        string                name;
        alu_op_e              alu_op;
        br_op_e               br_op;
        mem_op_e              mem_op;
        logic [`EXE_XLEN-1:0] rs;
        logic [`EXE_XLEN-1:0] rt;
        logic [`EXE_XLEN-1:0] imm;
        logic                 src2_is_imm;
        logic [`EXE_XLEN-1:0] imm_target;
        logic                 pred_valid;
        logic                 pred_taken;
        logic [`EXE_XLEN-1:0] pred_target;
        logic                 gr_we;
        logic                 ex;
        exc_code_e            code;
        int                   stall;       // cycles of out_allowin low
        logic [`EXE_XLEN-1:0] exp_result;
        logic                 exp_gr_we;
        logic [3:0]           exp_wen;
        logic [`EXE_XLEN-1:0] exp_wdata;
        exc_code_e            exp_code;
        logic                 exp_taken;
        logic [`EXE_XLEN-1:0] exp_target;
        logic                 exp_flush;
    } vec_t;

    logic                   clk;
    logic                   reset;
    logic                   flush;
    logic                   in_valid;
    logic [`EXE_XLEN-1:0]   in_pc;
    alu_op_e                in_alu_op;
    br_op_e                 in_br_op;
    mem_op_e                in_mem_op;
    logic [`EXE_XLEN-1:0]   in_rs_value;
    logic [`EXE_XLEN-1:0]   in_rt_value;
    logic [`EXE_XLEN-1:0]   in_imm;
    logic                   in_src2_is_imm;
    logic [`EXE_XLEN-1:0]   in_imm_target;
    logic                   in_pred_valid;
    logic                   in_pred_taken;
    logic [`EXE_XLEN-1:0]   in_pred_target;
    logic [`EXE_REG_AW-1:0] in_dest;
    logic                   in_gr_we;
    logic                   in_ex;
    exc_code_e              in_exc_code;
    logic                   out_allowin;
    logic                   allowin;
    logic                   out_valid;
    logic [`EXE_XLEN-1:0]   out_pc;
    logic [`EXE_XLEN-1:0]   out_result;
    logic [`EXE_REG_AW-1:0] out_dest;
    logic                   out_gr_we;
    logic                   out_mem_we;
    logic [`EXE_LANES-1:0]  out_mem_wen;
    logic [`EXE_XLEN-1:0]   out_mem_wdata;
    logic                   out_ex;
    exc_code_e              out_exc_code;
    logic                   br_taken;
    logic [`EXE_XLEN-1:0]   br_target;
    logic                   br_flush;

    vec_t  vecs[$];
    string cur_test;
    int    errors;
    int    test_errors;
    int    tests;
    int    failed_tests;

    exe_stage UUT (.*);

    always #10 clk = ~clk;

    function automatic vec_t blank_row(input string name, input logic [31:0] rt);
        vec_t r;
        r = '{name: name, alu_op: ALU_ADDU, br_op: BR_NONE, mem_op: MEM_NONE,
              rt: rt, exp_wdata: rt, code: EXC_NONE, exp_code: EXC_NONE, default: 0};
        return r;
    endfunction

    function automatic vec_t alu_row(input string name, input alu_op_e op, input logic [31:0] a,
                                     input logic [31:0] b, input logic [31:0] exp,
                                     input exc_code_e code);
        vec_t r;
        r = blank_row(name, b);
        r.alu_op = op;
        r.rs = a;
        r.gr_we = 1'b1;
        r.exp_result = exp;
        r.exp_code = code;
        r.exp_gr_we = (code == EXC_NONE);
        return r;
    endfunction

    function automatic vec_t br_row(input string name, input br_op_e op, input logic [31:0] rs,
                                    input logic [31:0] rt, input logic [31:0] tgt,
                                    input logic pv, input logic pt, input logic [31:0] ptgt,
                                    input logic taken, input logic [31:0] exp_tgt,
                                    input logic flush_exp);
        vec_t r;
        r = blank_row(name, rt);
        r.br_op = op;
        r.rs = rs;
        r.imm_target = tgt;
        r.pred_valid = pv;
        r.pred_taken = pt;
        r.pred_target = ptgt;
        r.gr_we = (op == BR_JAL);       // only jal links
        r.exp_gr_we = (op == BR_JAL);
        r.exp_result = (op == BR_JAL) ? BASE_PC + 32'd8 : rs + rt;
        r.exp_taken = taken;
        r.exp_target = exp_tgt;
        r.exp_flush = flush_exp;
        return r;
    endfunction

    function automatic vec_t mem_row(input string name, input mem_op_e op, input logic [31:0] base,
                                     input logic [31:0] off, input logic [31:0] rt,
                                     input logic [3:0] wen, input logic [31:0] wdata,
                                     input exc_code_e code);
        vec_t r;
        logic is_store;
        r = blank_row(name, rt);
        is_store = (op == MEM_SB) || (op == MEM_SH) || (op == MEM_SW);
        r.mem_op = op;
        r.rs = base;
        r.imm = off;
        r.src2_is_imm = 1'b1;   // address is base plus offset
        r.gr_we = ~is_store;
        r.exp_gr_we = ~is_store && (code == EXC_NONE);
        r.exp_result = base + off;
        r.exp_wen = (code == EXC_NONE) ? wen : 4'b0000;
        r.exp_wdata = wdata;
        r.exp_code = code;
        return r;
    endfunction

    function automatic logic [31:0] ref_alu(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            ALU_ADD, ALU_ADDU: return a + b;
            ALU_SUB, ALU_SUBU: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_NOR: return ~(a | b);
            ALU_SLT: return {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'd0, a < b};
            ALU_SLL: return b << a[4:0];
            ALU_SRL: return b >> a[4:0];
            ALU_SRA: return $signed(b) >>> a[4:0];
            default: return {b[15:0], 16'h0000};
        endcase
    endfunction

    function automatic logic ref_ov(input alu_op_e op, input logic [31:0] a, input logic [31:0] b);
        logic [31:0] s;
        s = ref_alu(op, a, b);
        if (op == ALU_ADD) return (a[31] == b[31]) && (s[31] != a[31]);
        if (op == ALU_SUB) return (a[31] != b[31]) && (s[31] != a[31]);
        return 1'b0;
    endfunction

    task automatic add_random_rows(input int count);
        alu_op_e     op;
        logic [31:0] a;
        logic [31:0] b;
        for (int k = 0; k < count; k++) begin
            op = alu_op_e'($urandom_range(13, 0));
            a = $urandom;
            b = $urandom;
            vecs.push_back(alu_row($sformatf("rand_%0d_%s", k, op.name()), op, a, b,
                                   ref_alu(op, a, b), ref_ov(op, a, b) ? EXC_OV : EXC_NONE));
        end
    endtask

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests++;
        if (test_errors != 0) failed_tests++;
        $display("test %s: %s", cur_test, (test_errors == 0) ? "ok" : "mismatch");
    endtask

    task automatic give_up(input string what);
        $display("timeout: %s did not rise within %0d cycles in test %s",
                 what, WAIT_LIMIT, cur_test);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic wait_allowin();
        int n;
        n = 0;
        @(negedge clk);
        while (!allowin) begin
            n++;
            if (n >= WAIT_LIMIT) give_up("allowin");
            @(negedge clk);
        end
    endtask

    task automatic wait_out_valid(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) give_up("out_valid");
        end while (!out_valid);
    endtask

    task automatic apply_inputs(input vec_t r);
        in_pc          <= BASE_PC;
        in_alu_op      <= r.alu_op;
        in_br_op       <= r.br_op;
        in_mem_op      <= r.mem_op;
        in_rs_value    <= r.rs;
        in_rt_value    <= r.rt;
        in_imm         <= r.imm;
        in_src2_is_imm <= r.src2_is_imm;
        in_imm_target  <= r.imm_target;
        in_pred_valid  <= r.pred_valid;
        in_pred_taken  <= r.pred_taken;
        in_pred_target <= r.pred_target;
        in_dest        <= 5'd9;
        in_gr_we       <= r.gr_we;
        in_ex          <= r.ex;
        in_exc_code    <= r.code;
    endtask

    task automatic check_outputs(input vec_t r);
        check("out_valid", 1, out_valid);
        check("out_pc", BASE_PC, out_pc);
        check("out_result", r.exp_result, out_result);
        check("out_dest", 9, out_dest);
        check("out_gr_we", r.exp_gr_we, out_gr_we);
        check("out_mem_we", r.exp_wen != 0, out_mem_we);
        check("out_mem_wen", r.exp_wen, out_mem_wen);
        check("out_mem_wdata", r.exp_wdata, out_mem_wdata);
        check("out_ex", r.exp_code != EXC_NONE, out_ex);
        check("out_exc_code", r.exp_code, out_exc_code);
        check("br_taken", r.exp_taken, br_taken);
        if (r.exp_taken) check("br_target", r.exp_target, br_target);
        check("br_flush", r.exp_flush, br_flush);
    endtask

    // offer one row, hold it for its stall cycles, then let it leave
    task automatic run_row(input vec_t r);
        int cycles;
        start_test(r.name);
        @(posedge clk);
        apply_inputs(r);
        in_valid <= 1'b1;
        out_allowin <= (r.stall == 0);
        wait_allowin();
        @(posedge clk);   // accepting edge
        in_valid <= 1'b0;
        wait_out_valid(cycles);
        check("latency", 1, cycles);
        check_outputs(r);
        if (r.stall > 0) begin
            repeat (r.stall) begin
                @(negedge clk);
                check("allowin", 0, allowin);
                check_outputs(r);
            end
            @(posedge clk);
            out_allowin <= 1'b1;
            @(negedge clk);
            check_outputs(r);   // transfer happens on the next edge
        end
        @(negedge clk);
        check("out_valid after transfer", 0, out_valid);
        end_test();
    endtask

    task automatic back_to_back(input vec_t a, input vec_t b);
        start_test("back_to_back");
        @(posedge clk);
        apply_inputs(a);
        in_valid <= 1'b1;
        out_allowin <= 1'b1;
        wait_allowin();
        @(posedge clk);
        apply_inputs(b);
        @(negedge clk);
        check_outputs(a);
        check("allowin", 1, allowin);
        @(posedge clk);   // a leaves while b enters
        in_valid <= 1'b0;
        @(negedge clk);
        check_outputs(b);
        @(negedge clk);
        check("out_valid after transfer", 0, out_valid);
        end_test();
    endtask

    task automatic flush_held(input vec_t r);
        int cycles;
        start_test("flush");
        @(posedge clk);
        apply_inputs(r);
        in_valid <= 1'b1;
        out_allowin <= 1'b0;
        wait_allowin();
        @(posedge clk);
        in_valid <= 1'b0;
        wait_out_valid(cycles);
        check_outputs(r);
        @(posedge clk);
        flush <= 1'b1;
        @(negedge clk);
        check_outputs(r);   // flush is taken on the next edge
        @(posedge clk);
        flush <= 1'b0;
        out_allowin <= 1'b1;
        @(negedge clk);
        check("out_valid after flush", 0, out_valid);
        check("br_taken after flush", 0, br_taken);
        check("br_flush after flush", 0, br_flush);
        check("br_target after flush", 0, br_target);
        @(negedge clk);
        check("out_valid after release", 0, out_valid);
        end_test();
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        flush = 1'b0;
        in_valid = 1'b0;
        out_allowin = 1'b0;
        apply_inputs(blank_row("idle", 32'd0));
        errors = 0;
        tests = 0;
        failed_tests = 0;
        void'($urandom(32'h89077dc6));
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        start_test("reset");
        check("out_valid", 0, out_valid);
        check("br_flush", 0, br_flush);
        check("br_taken", 0, br_taken);
        check("allowin", 1, allowin);
        check("out_gr_we", 0, out_gr_we);
        check("out_mem_we", 0, out_mem_we);
        check("out_ex", 0, out_ex);
        end_test();
        fill_table();
        add_random_rows(8);
        foreach (vecs[i]) run_row(vecs[i]);
        back_to_back(vecs[0], vecs[2]);
        // mispredicted branch, so br_taken and br_flush are high while held
        flush_held(br_row("flush_bne", BR_BNE, 32'd5, 32'd6, 32'h80001100,
                          1, 1, 32'h80002000, 1, 32'h80001100, 1));
        $display("%0d tests, %0d failed, %0d mismatches", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    `include "exe_stage_vectors.svh"

endmodule

`default_nettype wire

// File: hw/exe_stage.sv
`timescale 1ns/1ps
`include "exe_config.svh"
`default_nettype none

module exe_stage import exe_isa_pkg::*, exe_exc_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   in_valid,
    input  logic [`EXE_XLEN-1:0]   in_pc,
    input  alu_op_e                in_alu_op,
    input  br_op_e                 in_br_op,
    input  mem_op_e                in_mem_op,
    input  logic [`EXE_XLEN-1:0]   in_rs_value,
    input  logic [`EXE_XLEN-1:0]   in_rt_value,
    input  logic [`EXE_XLEN-1:0]   in_imm,          // already extended by decode
    input  logic                   in_src2_is_imm,
    input  logic [`EXE_XLEN-1:0]   in_imm_target,
    input  logic                   in_pred_valid,
    input  logic                   in_pred_taken,
    input  logic [`EXE_XLEN-1:0]   in_pred_target,
    input  logic [`EXE_REG_AW-1:0] in_dest,
    input  logic                   in_gr_we,
    input  logic                   in_ex,
    input  exc_code_e              in_exc_code,
    input  logic                   out_allowin,
    output logic                   allowin,
    output logic                   out_valid,
    output logic [`EXE_XLEN-1:0]   out_pc,
    output logic [`EXE_XLEN-1:0]   out_result,
    output logic [`EXE_REG_AW-1:0] out_dest,
    output logic                   out_gr_we,
    output logic                   out_mem_we,
    output logic [`EXE_LANES-1:0]  out_mem_wen,
    output logic [`EXE_XLEN-1:0]   out_mem_wdata,
    output logic                   out_ex,
    output exc_code_e              out_exc_code,
    output logic                   br_taken,
    output logic [`EXE_XLEN-1:0]   br_target,
    output logic                   br_flush
);

    logic                   valid;
    logic [`EXE_XLEN-1:0]   pc_r;
    alu_op_e                alu_op_r;
    br_op_e                 br_op_r;
    mem_op_e                mem_op_r;
    logic [`EXE_XLEN-1:0]   rs_r;
    logic [`EXE_XLEN-1:0]   rt_r;
    logic [`EXE_XLEN-1:0]   imm_r;
    logic                   src2_is_imm_r;
    logic [`EXE_XLEN-1:0]   imm_target_r;
    logic                   pred_valid_r;
    logic                   pred_taken_r;
    logic [`EXE_XLEN-1:0]   pred_target_r;
    logic [`EXE_REG_AW-1:0] dest_r;
    logic                   gr_we_r;
    logic                   ex_r;
    exc_code_e              exc_code_r;

    logic                   capture;
    logic [`EXE_XLEN-1:0]   alu_src2;
    logic [`EXE_XLEN-1:0]   alu_result;
    logic                   overflow;
    logic                   taken;
    logic [`EXE_XLEN-1:0]   target;
    logic                   flush_req;
    logic [`EXE_XLEN-1:0]   link_value;
    logic [`EXE_LANES-1:0]  wen;
    logic                   ades;
    logic                   adel;
    logic                   ex_any;
    logic                   commit_ok;   // valid and no exception

    // single-cycle stage, so ready_go is always high
    assign allowin = ~valid || out_allowin;
    assign capture = in_valid && allowin && ~flush;   // flush beats acceptance

    always_ff @(posedge clk) begin
        if (reset) begin
            valid        <= 1'b0;
            pc_r         <= `EXE_RESET_PC;
            br_op_r      <= BR_NONE;
            mem_op_r     <= MEM_NONE;
            pred_valid_r <= 1'b0;
            gr_we_r      <= 1'b0;
            ex_r         <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= in_valid;
            if (in_valid) begin
                pc_r         <= in_pc;
                br_op_r      <= in_br_op;
                mem_op_r     <= in_mem_op;
                pred_valid_r <= in_pred_valid;
                gr_we_r      <= in_gr_we;
                ex_r         <= in_ex;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            alu_op_r      <= in_alu_op;
            rs_r          <= in_rs_value;
            rt_r          <= in_rt_value;
            imm_r         <= in_imm;
            src2_is_imm_r <= in_src2_is_imm;
            imm_target_r  <= in_imm_target;
            pred_taken_r  <= in_pred_taken;
            pred_target_r <= in_pred_target;
            dest_r        <= in_dest;
            exc_code_r    <= in_exc_code;
        end
    end

    assign alu_src2 = src2_is_imm_r ? imm_r : rt_r;

    exe_alu u_alu (
        .op       (alu_op_r),
        .src1     (rs_r),
        .src2     (alu_src2),
        .result   (alu_result),
        .overflow (overflow)
    );

    exe_branch_unit u_branch (
        .br_op       (br_op_r),
        .pc          (pc_r),
        .rs_value    (rs_r),
        .rt_value    (rt_r),
        .imm_target  (imm_target_r),
        .pred_valid  (pred_valid_r),
        .pred_taken  (pred_taken_r),
        .pred_target (pred_target_r),
        .taken       (taken),
        .target      (target),
        .flush_req   (flush_req),
        .link_value  (link_value)
    );

    // alu result doubles as the data address
    exe_mem_align u_mem_align (
        .mem_op   (mem_op_r),
        .addr     (alu_result),
        .rt_value (rt_r),
        .wen      (wen),
        .wdata    (out_mem_wdata),
        .ades     (ades),
        .adel     (adel)
    );

    assign ex_any    = ex_r || overflow || ades || adel;
    assign commit_ok = valid && ~ex_any;

    assign out_valid    = valid;
    assign out_pc       = pc_r;
    assign out_result   = (br_op_r == BR_JAL) ? link_value : alu_result;
    assign out_dest     = dest_r;
    assign out_gr_we    = commit_ok && gr_we_r;
    assign out_mem_we   = commit_ok && (|wen);   // only stores enable lanes
    assign out_mem_wen  = out_mem_we ? wen : '0;
    assign out_ex       = valid && ex_any;
    assign out_exc_code = valid ? exc_select(ex_r, exc_code_r, overflow, ades, adel) : EXC_NONE;

    assign br_taken  = valid && taken;
    assign br_target = valid ? target : '0;
    assign br_flush  = valid && flush_req;

endmodule

`default_nettype wire

// File: hw/exe_mem_align.sv
`timescale 1ns/1ps
`include "exe_config.svh"
`default_nettype none

module exe_mem_align import exe_isa_pkg::*; (
    input  mem_op_e                mem_op,
    input  logic [`EXE_XLEN-1:0]   addr,
    input  logic [`EXE_XLEN-1:0]   rt_value,
    output logic [`EXE_LANES-1:0]  wen,
    output logic [`EXE_XLEN-1:0]   wdata,
    output logic                   ades,
    output logic                   adel
);

    logic [1:0] offset;

    assign offset = addr[1:0];

    always_comb begin
        case (mem_op)
            MEM_SB: begin
                wen   = `EXE_LANES'(1) << offset;   // one lane per byte offset
                wdata = {4{rt_value[7:0]}};
            end
            MEM_SH: begin
                wen   = offset[1] ? 4'b1100 : 4'b0011;
                wdata = {2{rt_value[15:0]}};
            end
            MEM_SW: begin
                wen   = {`EXE_LANES{1'b1}};
                wdata = rt_value;
            end
            default: begin
                wen   = '0;   // loads and non-memory ops
                wdata = rt_value;
            end
        endcase
    end

    assign ades = ((mem_op == MEM_SH) && offset[0]) ||
                  ((mem_op == MEM_SW) && (offset != 2'b00));

    // lb has no alignment rule
    assign adel = (((mem_op == MEM_LH) || (mem_op == MEM_LHU)) && offset[0]) ||
                  ((mem_op == MEM_LW) && (offset != 2'b00));

endmodule

`default_nettype wire

// File: hw/exe_branch_unit.sv
`timescale 1ns/1ps
`include "exe_config.svh"
`default_nettype none

module exe_branch_unit import exe_isa_pkg::*; (
    input  br_op_e                br_op,
    input  logic [`EXE_XLEN-1:0]  pc,
    input  logic [`EXE_XLEN-1:0]  rs_value,
    input  logic [`EXE_XLEN-1:0]  rt_value,
    input  logic [`EXE_XLEN-1:0]  imm_target,   // pc-relative target or jump index
    input  logic                  pred_valid,
    input  logic                  pred_taken,
    input  logic [`EXE_XLEN-1:0]  pred_target,
    output logic                  taken,
    output logic [`EXE_XLEN-1:0]  target,
    output logic                  flush_req,
    output logic [`EXE_XLEN-1:0]  link_value
);

    logic                 is_branch;
    logic                 rs_eq_rt;
    logic                 rs_ltz;
    logic                 rs_gtz;
    logic                 pred_right;
    logic [`EXE_XLEN-1:0] jump_target;

    assign is_branch = (br_op != BR_NONE);
    assign rs_eq_rt  = (rs_value == rt_value);
    assign rs_ltz    = rs_value[`EXE_XLEN-1];
    assign rs_gtz    = ~rs_value[`EXE_XLEN-1] && (|rs_value);

    // 256MB region of the current pc
    assign jump_target = {pc[31:28], imm_target[25:0], 2'b00};

    always_comb begin
        case (br_op)
            BR_BEQ:  taken = rs_eq_rt;
            BR_BNE:  taken = ~rs_eq_rt;
            BR_BGEZ: taken = ~rs_ltz;
            BR_BGTZ: taken = rs_gtz;
            BR_BLEZ: taken = ~rs_gtz;
            BR_BLTZ: taken = rs_ltz;
            BR_J,
            BR_JAL,
            BR_JR:   taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (br_op)
            BR_JR:   target = rs_value;
            BR_J,
            BR_JAL:  target = jump_target;
            default: target = imm_target;
        endcase
    end

    assign link_value = pc + 32'd8;   // skips the delay slot

    // not-taken is right only if front end also fell through
    assign pred_right = taken ? (pred_target == target) : ~pred_taken;

    // without a prediction the front end fetched sequentially
    assign flush_req = pred_valid ? (is_branch && ~pred_right) : taken;

endmodule

`default_nettype wire

// File: hw/exe_alu.sv
`timescale 1ns/1ps
`include "exe_config.svh"
`default_nettype none

module exe_alu import exe_isa_pkg::*; (
    input  alu_op_e               op,
    input  logic [`EXE_XLEN-1:0]  src1,
    input  logic [`EXE_XLEN-1:0]  src2,
    output logic [`EXE_XLEN-1:0]  result,
    output logic                  overflow
);

    localparam int MSB = `EXE_XLEN - 1;

    logic                 is_sub;     // add/sub share one adder
    logic                 check_ov;
    logic [`EXE_XLEN-1:0] add_b;
    logic [`EXE_XLEN-1:0] sum;
    logic [4:0]           shamt;
    logic                 lt_signed;
    logic                 lt_unsigned;

    assign is_sub   = (op == ALU_SUB) || (op == ALU_SUBU);
    assign check_ov = (op == ALU_ADD) || (op == ALU_SUB);

    assign add_b = is_sub ? ~src2 : src2;
    assign sum   = src1 + add_b + {{(`EXE_XLEN-1){1'b0}}, is_sub};   // +1 completes two's complement

    // operands agree in sign but the sum does not
    assign overflow = check_ov && (src1[MSB] == add_b[MSB]) && (sum[MSB] != src1[MSB]);

    assign shamt       = src1[4:0];   // shift amount from src1
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (op)
            ALU_ADD,
            ALU_ADDU,
            ALU_SUB,
            ALU_SUBU: begin
                result = sum;
            end
            ALU_AND: begin
                result = src1 & src2;
            end
            ALU_OR: begin
                result = src1 | src2;
            end
            ALU_XOR: begin
                result = src1 ^ src2;
            end
            ALU_NOR: begin
                result = ~(src1 | src2);
            end
            ALU_SLT: begin
                result = {{(`EXE_XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                result = {{(`EXE_XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_SLL: begin
                result = src2 << shamt;
            end
            ALU_SRL: begin
                result = src2 >> shamt;
            end
            ALU_SRA: begin
                result = $signed(src2) >>> shamt;   // keeps sign bit
            end
            ALU_LUI: begin
                result = {src2[15:0], 16'h0000};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/exe_exc_pkg.sv
`default_nettype none

package exe_exc_pkg;

    // cp0 cause.exccode values
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } exc_code_e;

    // earliest source wins: decode, then overflow, then store, then load address
    function automatic exc_code_e exc_select(input logic dec_ex, input exc_code_e dec_code,
                                             input logic ov, input logic ades,
                                             input logic adel);
        if (dec_ex) return dec_code;
        if (ov) return EXC_OV;
        if (ades) return EXC_ADES;
        if (adel) return EXC_ADEL;
        return EXC_NONE;
    endfunction

endpackage

`default_nettype wire

// File: hw/exe_isa_pkg.sv
`default_nettype none

package exe_isa_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,   // signed, traps on overflow
        ALU_ADDU = 4'd1,
        ALU_SUB  = 4'd2,   // signed, traps on overflow
        ALU_SUBU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_SLL  = 4'd10,
        ALU_SRL  = 4'd11,
        ALU_SRA  = 4'd12,
        ALU_LUI  = 4'd13
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_BEQ  = 4'd1,
        BR_BNE  = 4'd2,
        BR_BGEZ = 4'd3,
        BR_BGTZ = 4'd4,
        BR_BLEZ = 4'd5,
        BR_BLTZ = 4'd6,
        BR_J    = 4'd7,
        BR_JAL  = 4'd8,   // writes pc+8 to the link register
        BR_JR   = 4'd9
    } br_op_e;

    typedef enum logic [2:0] {
        MEM_NONE = 3'd0,
        MEM_LB   = 3'd1,
        MEM_LH   = 3'd2,
        MEM_LHU  = 3'd3,
        MEM_LW   = 3'd4,
        MEM_SB   = 3'd5,
        MEM_SH   = 3'd6,
        MEM_SW   = 3'd7
    } mem_op_e;

endpackage

`default_nettype wire

// File: hw/exe_config.svh
`default_nettype none

`ifndef EXE_CONFIG_SVH
`define EXE_CONFIG_SVH

// data path and address width
`define EXE_XLEN 32

// register file index width
`define EXE_REG_AW 5

// byte lanes in one word
`define EXE_LANES 4

// boot vector, kseg1 rom
`define EXE_RESET_PC 32'hbfc00000

`endif

`default_nettype wire
